// ==== hw/cart_pkg.sv ====
package cart_pkg;

	// Address and bank geometry
	localparam int BANK_W         = 7;        // 8 KB bank within 1 MB
	localparam int TABLE_DEPTH    = 64;
	localparam int TABLE_IDX_W    = $clog2(TABLE_DEPTH);
	localparam int ADDR_W         = 16;
	localparam int SDRAM_W        = 24;
	localparam int BANK_BIT       = 13;
	localparam int ROM_REGION_BIT = 23;       // Marks the cartridge bank region

	// Port widths
	localparam int CART_ID_W = 16;
	localparam int LOAD_W    = 16;            // CRT chip packet header fields
	localparam int DATA_W    = 8;
	localparam int CNT_W     = 8;

	// Chip packet decode
	localparam logic [LOAD_W-1:0] HI_LOAD_ADDR = 16'h8000;
	localparam logic [LOAD_W-1:0] BANK_BYTES   = 16'h2000;

	// Epyx capacitor model
	localparam int FASTLOAD_CYCLES = 16384;
	localparam int FAST_CNT_W      = $clog2(FASTLOAD_CYCLES + 1);

	// Supported CRT hardware types
	localparam logic [CART_ID_W-1:0] CART_GENERIC   = 16'd0;
	localparam logic [CART_ID_W-1:0] CART_OCEAN     = 16'd5;
	localparam logic [CART_ID_W-1:0] CART_EPYX      = 16'd10;
	localparam logic [CART_ID_W-1:0] CART_FC12      = 16'd13;
	localparam logic [CART_ID_W-1:0] CART_MAGICDESK = 16'd19;
	localparam logic [CART_ID_W-1:0] CART_EASYFLASH = 16'd32;

	// Freeze state codes
	localparam logic [1:0] FRZ_ARMED     = 2'd0;
	localparam logic [1:0] FRZ_REQUESTED = 2'd1;
	localparam logic [1:0] FRZ_FROZEN    = 2'd2;

	// CPU byte written to the IO area
	typedef union packed {
		struct packed {
			logic [DATA_W-TABLE_IDX_W-1:0] unused;
			logic [TABLE_IDX_W-1:0]        bank;
		} ef_bank;
		struct packed {
			logic [4:0] unused;
			logic       jumper;
			logic       exrom_n;
			logic       game_n;
		} ef_ctrl;
		struct packed {
			logic              exrom;
			logic [BANK_W-1:0] bank;
		} md_bank;
	} io_data_t;

endpackage

// ==== hw/bank_table.sv ====
`timescale 1ns/1ps

module bank_table import cart_pkg::*; (
	input  logic                   clk32,
	input  logic                   reset,
	input  logic                   cart_loading,
	input  logic                   cart_bank_wr,
	input  logic [LOAD_W-1:0]      cart_bank_num,
	input  logic [LOAD_W-1:0]      cart_bank_laddr,   // Load address from the chip packet
	input  logic [LOAD_W-1:0]      cart_bank_size,
	input  logic [SDRAM_W-1:0]     cart_bank_raddr,   // Where the packet sits in SDRAM
	input  logic [TABLE_IDX_W-1:0] sel_index,
	output logic [BANK_W-1:0]      lo_first,
	output logic [BANK_W-1:0]      hi_first,
	output logic [BANK_W-1:0]      lo_sel,
	output logic [BANK_W-1:0]      hi_sel,
	output logic [CNT_W-1:0]       bank_count
);

	logic [BANK_W-1:0] lo_banks [TABLE_DEPTH];
	logic [BANK_W-1:0] hi_banks [TABLE_DEPTH];
	logic              loading_q;
	logic [BANK_W-1:0] packet_bank;
	logic              in_range;

	assign packet_bank = cart_bank_raddr[BANK_BIT +: BANK_W];
	assign in_range    = (cart_bank_num < TABLE_DEPTH);

	// Table storage
	always_ff @(posedge clk32) begin
		if (cart_bank_wr && in_range) begin
			if (cart_bank_laddr <= HI_LOAD_ADDR) begin
				lo_banks[cart_bank_num[TABLE_IDX_W-1:0]] <= packet_bank;
				// 16 KB packet spills into the high half
				if (cart_bank_size > BANK_BYTES)
					hi_banks[cart_bank_num[TABLE_IDX_W-1:0]] <= packet_bank + 1'b1;
			end else begin
				hi_banks[cart_bank_num[TABLE_IDX_W-1:0]] <= packet_bank;
			end
		end
	end

	// Count restarts with each new CRT image
	always_ff @(posedge clk32) begin
		if (!reset) begin
			loading_q  <= 1'b0;
			bank_count <= '0;
		end else begin
			loading_q <= cart_loading;
			if (cart_loading && !loading_q)
				bank_count <= '0;
			else if (cart_bank_wr)
				bank_count <= bank_count + 1'b1;
		end
	end

	assign lo_first = lo_banks[0];
	assign hi_first = hi_banks[0];
	assign lo_sel   = lo_banks[sel_index];       // EasyFlash bank lookup
	assign hi_sel   = hi_banks[sel_index];

endmodule

// ==== hw/freeze_fsm.sv ====
`timescale 1ns/1ps

module freeze_fsm import cart_pkg::*; (
	input  logic clk32,
	input  logic reset,
	input  logic freeze_key,
	input  logic nmi_ack,
	input  logic arm,          // Freeze allowed at all
	input  logic rearm,        // Cartridge IO access after a freeze
	output logic nmi,
	output logic freeze_ack
);

	logic [1:0] state;
	logic       key_q;
	logic       ack_q;
	logic       key_edge;
	logic       ack_edge;

	assign key_edge = freeze_key & ~key_q;
	assign ack_edge = nmi_ack & ~ack_q;

	always_ff @(posedge clk32) begin
		if (!reset) begin
			state      <= FRZ_ARMED;
			key_q      <= 1'b0;
			ack_q      <= 1'b0;
			freeze_ack <= 1'b0;
		end else begin
			key_q      <= freeze_key;
			ack_q      <= nmi_ack;
			freeze_ack <= 1'b0;
			case (state)
				FRZ_ARMED: begin
					if (arm && key_edge)
						state <= FRZ_REQUESTED;
				end
				FRZ_REQUESTED: begin
					// CPU has taken the NMI
					if (ack_edge) begin
						state      <= FRZ_FROZEN;
						freeze_ack <= 1'b1;
					end
				end
				FRZ_FROZEN: begin
					if (rearm)
						state <= FRZ_ARMED;
				end
				default: state <= FRZ_ARMED;
			endcase
		end
	end

	assign nmi = (state == FRZ_REQUESTED);

endmodule

// ==== hw/fastload_timer.sv ====
`timescale 1ns/1ps

module fastload_timer import cart_pkg::*; (
	input  logic clk32,
	input  logic reset,
	input  logic charge,       // ROM or IO access tops up the capacitor
	input  logic enable,
	output logic expired
);

	logic [FAST_CNT_W-1:0] count;

	// Starts full so the cartridge is visible at power up
	always_ff @(posedge clk32) begin
		if (!reset) begin
			count <= FAST_CNT_W'(FASTLOAD_CYCLES);
		end else if (charge) begin
			count <= FAST_CNT_W'(FASTLOAD_CYCLES);
		end else if (enable && count != '0) begin
			count <= count - 1'b1;
		end
	end

	assign expired = (count == '0);  // Held until the next charge

endmodule

// ==== hw/mapper_regs.sv ====
`timescale 1ns/1ps

module mapper_regs import cart_pkg::*; (
	input  logic                   clk32,
	input  logic                   reset,
	input  logic [CART_ID_W-1:0]   cart_id,
	input  logic [DATA_W-1:0]      cart_exrom,
	input  logic [DATA_W-1:0]      cart_game,
	input  logic                   ioe,
	input  logic                   iof,
	input  logic                   rom_l,
	input  logic                   mem_write,
	input  logic [ADDR_W-1:0]      c64_address,
	input  logic [DATA_W-1:0]      c64_data,
	input  logic [BANK_W-1:0]      lo_first,
	input  logic [BANK_W-1:0]      hi_first,
	input  logic [BANK_W-1:0]      lo_sel,
	input  logic [BANK_W-1:0]      hi_sel,
	input  logic [CNT_W-1:0]       bank_count,
	input  logic                   freeze_ack,
	input  logic                   expired,
	output logic [TABLE_IDX_W-1:0] sel_index,
	output logic [BANK_W-1:0]      bank_lo,
	output logic [BANK_W-1:0]      bank_hi,
	output logic [BANK_W-1:0]      ioe_bank,
	output logic [BANK_W-1:0]      iof_bank,
	output logic                   ioe_ena,
	output logic                   iof_ena,
	output logic                   exrom_override,
	output logic                   game_override,
	output logic                   fastload_charge,
	output logic                   fastload_enable,
	output logic                   freeze_rearm
);

	logic     ioe_q;
	logic     iof_q;
	logic     stb_ioe;
	logic     stb_iof;
	logic     ioe_wr;
	logic     init_n;      // Low for one cycle after reset
	io_data_t io_d;

	assign stb_ioe = ioe & ~ioe_q;
	assign stb_iof = iof & ~iof_q;
	assign ioe_wr  = stb_ioe & mem_write;
	assign io_d    = io_data_t'(c64_data);

	assign sel_index       = io_d.ef_bank.bank;
	assign fastload_charge = (cart_id == CART_EPYX) & (~init_n | ioe | rom_l);
	assign freeze_rearm    = (cart_id == CART_FC12) & stb_ioe;

	always_ff @(posedge clk32) begin
		if (!reset) begin
			ioe_q           <= 1'b0;
			iof_q           <= 1'b0;
			init_n          <= 1'b0;
			bank_lo         <= '0;
			bank_hi         <= '0;
			ioe_bank        <= '0;
			iof_bank        <= '0;
			ioe_ena         <= 1'b0;
			iof_ena         <= 1'b0;
			exrom_override  <= 1'b1;
			game_override   <= 1'b1;
			fastload_enable <= 1'b0;
		end else begin
			ioe_q  <= ioe;
			iof_q  <= iof;
			init_n <= 1'b1;

			case (cart_id)
				// Lines straight from the CRT header
				CART_GENERIC: begin
					exrom_override <= cart_exrom[0];
					game_override  <= cart_game[0];
					bank_lo        <= lo_first;
					bank_hi        <= hi_first;
				end

				// Same bank mirrored at $8000 and $A000
				CART_OCEAN: begin
					exrom_override <= 1'b0;
					game_override  <= 1'b0;
					if (ioe_wr) begin
						bank_lo <= {1'b0, c64_data[5:0]};
						bank_hi <= {1'b0, c64_data[5:0]};
					end
				end

				CART_EPYX: begin
					if (fastload_charge) begin
						fastload_enable <= init_n;     // Timer idles until first access
						exrom_override  <= 1'b0;
						game_override   <= 1'b1;
						iof_ena         <= 1'b1;
						iof_bank        <= '0;
					end else if (fastload_enable && expired) begin
						exrom_override <= 1'b1;       // Capacitor drained, cart off
					end
				end

				// ******************************************************************
				// Final Cartridge 1/2, IOE hides the ROM and IOF restores it
				// ******************************************************************
				CART_FC12: begin
					if (!init_n) begin
						bank_lo        <= '0;
						bank_hi        <= 7'd1;
						exrom_override <= 1'b0;
						game_override  <= 1'b0;
						ioe_bank       <= '0;
						iof_bank       <= '0;
						ioe_ena        <= 1'b1;
						iof_ena        <= 1'b1;
					end
					if (freeze_ack)
						game_override <= 1'b0;        // Ultimax for the freeze menu
					if (stb_ioe) begin
						exrom_override <= 1'b1;
						game_override  <= 1'b1;
					end
					if (stb_iof) begin
						exrom_override <= 1'b0;
						game_override  <= 1'b0;
					end
				end

				CART_MAGICDESK: begin
					if (!init_n) begin
						exrom_override <= 1'b0;
						game_override  <= 1'b1;
						bank_lo        <= '0;
					end
					if (ioe_wr) begin
						// Bank width follows the image size
						if (bank_count <= 8'd16)
							bank_lo <= {3'b000, io_d.md_bank.bank[3:0]};
						else if (bank_count <= 8'd32)
							bank_lo <= {2'b00, io_d.md_bank.bank[4:0]};
						else if (bank_count <= 8'd64)
							bank_lo <= {1'b0, io_d.md_bank.bank[5:0]};
						else
							bank_lo <= io_d.md_bank.bank;
						exrom_override <= io_d.md_bank.exrom;
					end
				end

				// ******************************************************************
				// EasyFlash, $DE00 bank select and $DE02 control
				// ******************************************************************
				CART_EASYFLASH: begin
					if (!init_n) begin
						iof_bank       <= '0;
						iof_ena        <= 1'b1;
						exrom_override <= 1'b1;       // Boot in Ultimax
						game_override  <= 1'b0;
						bank_lo        <= lo_first;
						bank_hi        <= hi_first;
					end
					if (ioe_wr) begin
						if (c64_address[1]) begin
							game_override  <= ~io_d.ef_ctrl.game_n & io_d.ef_ctrl.jumper;
							exrom_override <= ~io_d.ef_ctrl.exrom_n;
						end else begin
							bank_lo <= lo_sel;
							bank_hi <= hi_sel;
						end
					end
				end

				default: ;
			endcase
		end
	end

endmodule

// ==== hw/addr_translate.sv ====
`timescale 1ns/1ps

module addr_translate import cart_pkg::*; (
	input  logic               cart_attached,
	input  logic               rom_l,
	input  logic               rom_h,
	input  logic               ioe,
	input  logic               iof,
	input  logic               mem_write,
	input  logic               mem_ce,
	input  logic [ADDR_W-1:0]  c64_address,
	input  logic [BANK_W-1:0]  bank_lo,
	input  logic [BANK_W-1:0]  bank_hi,
	input  logic [BANK_W-1:0]  ioe_bank,
	input  logic [BANK_W-1:0]  iof_bank,
	input  logic               ioe_ena,
	input  logic               iof_ena,
	output logic [SDRAM_W-1:0] sdram_address,
	output logic               mem_ce_out
);

	logic ioe_ce;
	logic iof_ce;

	// Low address bits kept, bank and region bit above them
	function automatic logic [SDRAM_W-1:0] map_bank(input logic [BANK_W-1:0] bank,
	                                                input logic [ADDR_W-1:0] addr);
		logic [SDRAM_W-1:0] mapped;
		mapped                       = '0;
		mapped[BANK_BIT-1:0]         = addr[BANK_BIT-1:0];
		mapped[BANK_BIT +: BANK_W]   = bank;
		mapped[ROM_REGION_BIT]       = 1'b1;
		return mapped;
	endfunction

	assign ioe_ce     = ioe & ioe_ena & ~mem_write;   // IO pages are read only here
	assign iof_ce     = iof & iof_ena & ~mem_write;
	assign mem_ce_out = mem_ce | ioe_ce | iof_ce;

	always_comb begin
		sdram_address = SDRAM_W'(c64_address);
		if (cart_attached) begin
			if (rom_l && !mem_write) sdram_address = map_bank(bank_lo, c64_address);
			if (rom_h && !mem_write) sdram_address = map_bank(bank_hi, c64_address);
			if (ioe_ce)              sdram_address = map_bank(ioe_bank, c64_address);  // $DExx
			if (iof_ce)              sdram_address = map_bank(iof_bank, c64_address);  // $DFxx
		end
	end

endmodule

// ==== hw/cartridge_top.sv ====
`timescale 1ns/1ps

module cartridge_top import cart_pkg::*; (
	input  logic                 clk32,
	input  logic                 reset,
	input  logic                 romL,
	input  logic                 romH,
	input  logic                 IOE,
	input  logic                 IOF,
	input  logic                 mem_write,
	input  logic                 mem_ce,
	input  logic [CART_ID_W-1:0] cart_id,
	input  logic [DATA_W-1:0]    cart_exrom,
	input  logic [DATA_W-1:0]    cart_game,
	input  logic [LOAD_W-1:0]    cart_bank_laddr,
	input  logic [LOAD_W-1:0]    cart_bank_size,
	input  logic [LOAD_W-1:0]    cart_bank_num,
	input  logic [SDRAM_W-1:0]   cart_bank_raddr,
	input  logic                 cart_bank_wr,
	input  logic                 cart_attached,
	input  logic                 cart_loading,
	input  logic [ADDR_W-1:0]    c64_mem_address_in,
	input  logic [DATA_W-1:0]    c64_data_out,
	input  logic                 freeze_key,
	input  logic                 nmi_ack,
	output logic [SDRAM_W-1:0]   sdram_address_out,
	output logic                 mem_ce_out,
	output logic                 exrom,
	output logic                 game,
	output logic                 nmi
);

	logic [TABLE_IDX_W-1:0] sel_index;
	logic [BANK_W-1:0]      lo_first, hi_first, lo_sel, hi_sel;
	logic [CNT_W-1:0]       bank_count;
	logic [BANK_W-1:0]      bank_lo, bank_hi, ioe_bank, iof_bank;
	logic                   ioe_ena, iof_ena;
	logic                   exrom_override, game_override;
	logic                   fastload_charge, fastload_enable, expired;
	logic                   freeze_rearm, freeze_ack;

	// Lines float high with no cartridge
	assign exrom = ~cart_attached | exrom_override;
	assign game  = ~cart_attached | game_override;

	bank_table u_bank_table (
		.clk32, .reset, .cart_loading, .cart_bank_wr, .cart_bank_num, .cart_bank_laddr,
		.cart_bank_size, .cart_bank_raddr, .sel_index,
		.lo_first, .hi_first, .lo_sel, .hi_sel, .bank_count
	);

	freeze_fsm u_freeze_fsm (
		.clk32, .reset, .freeze_key, .nmi_ack,
		.arm(cart_attached), .rearm(freeze_rearm), .nmi, .freeze_ack
	);

	fastload_timer u_fastload_timer (
		.clk32, .reset, .charge(fastload_charge), .enable(fastload_enable), .expired
	);

	mapper_regs u_mapper_regs (
		.clk32, .reset, .cart_id, .cart_exrom, .cart_game,
		.ioe(IOE), .iof(IOF), .rom_l(romL), .mem_write,
		.c64_address(c64_mem_address_in), .c64_data(c64_data_out),
		.lo_first, .hi_first, .lo_sel, .hi_sel, .bank_count, .freeze_ack, .expired,
		.sel_index, .bank_lo, .bank_hi, .ioe_bank, .iof_bank, .ioe_ena, .iof_ena,
		.exrom_override, .game_override, .fastload_charge, .fastload_enable, .freeze_rearm
	);

	addr_translate u_addr_translate (
		.cart_attached, .rom_l(romL), .rom_h(romH), .ioe(IOE), .iof(IOF), .mem_write,
		.mem_ce, .c64_address(c64_mem_address_in), .bank_lo, .bank_hi, .ioe_bank,
		.iof_bank, .ioe_ena, .iof_ena, .sdram_address(sdram_address_out), .mem_ce_out
	);

endmodule

// ==== bench/cart_checker.sv ====
`timescale 1ns/1ps

module cart_checker import cart_pkg::*; (
	input  logic               clk32,
	input  logic               check,          // Compare on this cycle's falling edge
	input  logic               check_addr,     // Address only valid during an access
	input  logic [15:0]        test_id,
	input  logic [SDRAM_W-1:0] exp_addr,
	input  logic [2:0]         exp_lines,      // exrom, game, nmi
	input  logic               exp_ce,
	input  logic [SDRAM_W-1:0] sdram_address,
	input  logic               mem_ce_out,
	input  logic               exrom,
	input  logic               game,
	input  logic               nmi,
	output logic [15:0]        tests_run,
	output logic [15:0]        tests_failed
);

	int mismatches;

	task automatic compare_value(input string name, input logic [SDRAM_W-1:0] expected,
	                             input logic [SDRAM_W-1:0] actual);
		if (actual !== expected) begin
			$display("[ERROR] %t %s expected %0h, got %0h", $time, name, expected, actual);
			mismatches++;
		end
	endtask

	initial begin
		$timeformat(-9, 0, " ns", 0);
		tests_run    = '0;
		tests_failed = '0;
	end

	// Falling edge sits half a cycle away from both DUT updates and stimulus
	always @(negedge clk32) begin
		if (check) begin
			mismatches = 0;
			if (check_addr)
				compare_value("sdram_address_out", exp_addr, sdram_address);
			compare_value("mem_ce_out", SDRAM_W'(exp_ce), SDRAM_W'(mem_ce_out));
			compare_value("exrom", SDRAM_W'(exp_lines[2]), SDRAM_W'(exrom));
			compare_value("game", SDRAM_W'(exp_lines[1]), SDRAM_W'(game));
			compare_value("nmi", SDRAM_W'(exp_lines[0]), SDRAM_W'(nmi));
			tests_run = tests_run + 1'b1;
			if (mismatches == 0) begin
				$display("Test %0d ok", test_id);
			end else begin
				tests_failed = tests_failed + 1'b1;
				$display("Test %0d failed with %0d mismatches", test_id, mismatches);
			end
		end
	end

endmodule

// ==== bench/cart_tb.sv ====
`timescale 1ns/1ps

module cart_tb import cart_pkg::*; ();

	logic                 clk32, reset;
	logic                 romL, romH, IOE, IOF, mem_write, mem_ce;
	logic [CART_ID_W-1:0] cart_id;
	logic [DATA_W-1:0]    cart_exrom, cart_game, c64_data_out;
	logic [LOAD_W-1:0]    cart_bank_laddr, cart_bank_size, cart_bank_num;
	logic [SDRAM_W-1:0]   cart_bank_raddr, sdram_address_out;
	logic                 cart_bank_wr, cart_attached, cart_loading;
	logic [ADDR_W-1:0]    c64_mem_address_in;
	logic                 freeze_key, nmi_ack, mem_ce_out, exrom, game, nmi;

	// Handoff to the checker
	logic               check, check_addr;
	logic [SDRAM_W-1:0] exp_addr;
	logic [2:0]         exp_lines;       // exrom, game, nmi
	logic               exp_ce;
	logic [15:0]        test_id, tests_run, tests_failed;
	logic               data_ready;
	int                 n_tests, idx, rand_seed, scratch;

	string       ops[$];
	logic [31:0] args[$];                // Four operands and four expected values per test

	cartridge_top u_dut (.*);

	cart_checker u_checker (
		.clk32, .check, .check_addr, .test_id, .exp_addr, .exp_lines, .exp_ce,
		.sdram_address(sdram_address_out), .mem_ce_out, .exrom, .game, .nmi,
		.tests_run, .tests_failed
	);

	initial begin
		clk32 = 1'b0;
		forever #5 clk32 = ~clk32;
	end

	// ******************************************************************
	// Stimulus helpers
	// ******************************************************************
	task automatic next_cycle();
		@(posedge clk32);
		#1;
	endtask

	// Checker compares on the falling edge inside this cycle
	task automatic pulse_check(input logic addr_too);
		check      = 1'b1;
		check_addr = addr_too;
		next_cycle();
		check      = 1'b0;
		check_addr = 1'b0;
	endtask

	task automatic reset_dut();
		reset = 1'b0;
		repeat (5) next_cycle();
		reset = 1'b1;
		next_cycle();                    // Type loads its initial values on this edge
	endtask

	task automatic init_inputs();
		reset = 1'b0;
		{romL, romH, IOE, IOF, mem_write, mem_ce} = '0;
		{cart_id, cart_exrom, cart_game, c64_data_out, c64_mem_address_in} = '0;
		{cart_bank_laddr, cart_bank_size, cart_bank_num, cart_bank_raddr} = '0;
		{cart_bank_wr, cart_loading, freeze_key, nmi_ack} = '0;
		cart_attached = 1'b1;
		{check, check_addr, test_id, exp_addr, exp_lines} = '0;
		exp_ce     = 1'b0;
		data_ready = 1'b0;
	endtask

	task automatic read_testdata();
		int          fd;
		int          count;
		int          k;
		string       line;
		string       op;
		logic [31:0] f [8];
		fd = $fopen("bench/cart_testdata.txt", "r");
		if (fd == 0) begin
			$display("Could not open bench/cart_testdata.txt");
		end else begin
			while ($fgets(line, fd) != 0) begin
				count = $sscanf(line, "%s %h %h %h %h %h %h %h %h", op,
				                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
				if (line.getc(0) != "#" && count == 9) begin
					ops.push_back(op);
					for (k = 0; k < 8; k++)
						args.push_back(f[k]);
				end
			end
			$fclose(fd);
		end
		n_tests = ops.size();
	endtask

	task automatic run_test(input int i);
		string       op;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] d;
		logic [12:0] low;
		logic        ce_bit;
		op        = ops[i];
		a         = args[i*8];
		b         = args[i*8+1];
		c         = args[i*8+2];
		d         = args[i*8+3];
		test_id   = 16'(i + 1);
		exp_addr  = SDRAM_W'(args[i*8+4]);
		exp_lines = {args[i*8+5] != 0, args[i*8+6] != 0, args[i*8+7] != 0};
		exp_ce    = 1'b0;
		if (op == "select") begin
			cart_loading = 1'b0;
			cart_id      = CART_ID_W'(a);
			cart_exrom   = DATA_W'(b);
			cart_game    = DATA_W'(c);
			reset_dut();
			pulse_check(1'b0);
		end else if (op == "load") begin
			cart_loading = 1'b1;         // Rising edge restarts the bank count
			next_cycle();
			cart_bank_num   = LOAD_W'(a);
			cart_bank_laddr = LOAD_W'(b);
			cart_bank_size  = LOAD_W'(c);
			cart_bank_raddr = SDRAM_W'(d);
			cart_bank_wr    = 1'b1;
			next_cycle();
			cart_bank_wr = 1'b0;
			pulse_check(1'b0);
		end else if (op == "iowrite") begin
			IOE                = (a == 32'he);
			IOF                = (a == 32'hf);
			mem_write          = 1'b1;
			c64_mem_address_in = ADDR_W'(b);
			c64_data_out       = DATA_W'(c);
			next_cycle();
			{IOE, IOF, mem_write} = '0;
			pulse_check(1'b0);           // Registers changed on the write edge
		end else if (op == "access") begin
			c64_mem_address_in = ADDR_W'(b);
			if (a == 32'h1 || a == 32'h2) begin
				low                      = 13'($urandom);
				ce_bit                   = 1'($urandom);
				c64_mem_address_in[12:0] = low;
				exp_addr[12:0]           = low;   // Offset inside the bank passes through
			end else begin
				ce_bit = 1'b1;
			end
			romL   = (a == 32'h1);
			romH   = (a == 32'h2);
			IOE    = (a == 32'he);
			IOF    = (a == 32'hf);
			mem_ce = ce_bit;
			exp_ce = ce_bit;             // ROM reads add no enable of their own
			pulse_check(1'b1);
			{romL, romH, IOE, IOF, mem_ce} = '0;
		end else if (op == "freeze") begin
			freeze_key = (a == 32'h0);
			nmi_ack    = (a == 32'h1);
			next_cycle();
			{freeze_key, nmi_ack} = '0;
			pulse_check(1'b0);
		end else if (op == "idle") begin
			repeat (a) next_cycle();
			pulse_check(1'b0);
		end else begin
			$display("Test %0d has an unknown operation %s and was not run", i + 1, op);
		end
	endtask

	// ******************************************************************
	// Main sequence and watchdog
	// ******************************************************************
	initial begin
		init_inputs();
		rand_seed = 6656;
		scratch   = $urandom(rand_seed);
		read_testdata();
		data_ready = 1'b1;
		reset_dut();
		for (idx = 0; idx < n_tests; idx++)
			run_test(idx);
		$display("Tests run %0d, passed %0d, failed %0d of %0d read",
		         tests_run, tests_run - tests_failed, tests_failed, n_tests);
		if (n_tests > 0 && tests_run == n_tests && tests_failed == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	// Worst case per line is one full fastload discharge
	initial begin
		wait (data_ready === 1'b1);
		repeat ((n_tests + 1) * (FASTLOAD_CYCLES + 100)) @(posedge clk32);
		$display("Run timed out before all %0d tests finished", n_tests);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// ==== bench/cart_testdata.txt ====
# op a b c d sdram_addr exrom game nmi (hex); sdram_addr checked on access lines only
# a-d: select id,ex,gm load num,laddr,size,raddr iowrite e/f,adr,dat access 1/2/e/f,adr idle n
select  0 0 0 0             000000 0 0 0
load    0 8000 2000 020000  000000 0 0 0
load    0 a000 2000 040000  000000 0 0 0
access  1 8000 0 0          820000 0 0 0
access  2 a000 0 0          840000 0 0 0
select  5 0 0 0             000000 0 0 0
iowrite e de00 03 0         000000 0 0 0
access  2 a000 0 0          806000 0 0 0
iowrite e de00 c5 0         000000 0 0 0
access  1 8000 0 0          80a000 0 0 0
select  13 0 0 0            000000 0 1 0
iowrite e de00 1a 0         000000 0 1 0
access  1 8000 0 0          814000 0 1 0
iowrite e de00 85 0         000000 1 1 0
select  20 0 0 0            000000 1 0 0
load    1 8000 4000 060000  000000 1 0 0
iowrite e de00 01 0         000000 1 0 0
access  1 8000 0 0          860000 1 0 0
access  2 a000 0 0          862000 1 0 0
iowrite e de02 06 0         000000 0 1 0
select  d 0 0 0             000000 0 0 0
iowrite e de00 00 0         000000 1 1 0
iowrite f df00 00 0         000000 0 0 0
freeze  0 0 0 0             000000 0 0 1
iowrite e de00 00 0         000000 1 1 1
freeze  1 0 0 0             000000 1 1 0
idle    1 0 0 0             000000 1 0 0
freeze  0 0 0 0             000000 1 0 0
select  a 0 0 0             000000 0 1 0
access  1 8000 0 0          800000 0 1 0
idle    2710 0 0 0          000000 0 1 0
access  1 8000 0 0          800000 0 1 0
idle    2710 0 0 0          000000 0 1 0
idle    1b58 0 0 0          000000 1 1 0

// ==== project.f ====
hw/cart_pkg.sv
hw/bank_table.sv
hw/freeze_fsm.sv
hw/fastload_timer.sv
hw/mapper_regs.sv
hw/addr_translate.sv
hw/cartridge_top.sv
bench/cart_checker.sv
bench/cart_tb.sv
